/* list.f */
src/ppuPkg.sv
src/spriteRam.sv
src/scanTimer.sv
src/eightRam.sv
src/spriteLineUnit.sv
testbench/tbSpriteLine.sv

/* run.sh */
#!/bin/sh
# build and run the sprite line testbench with Verilator
# exit status is zero only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tbSpriteLine

rm -rf "$BUILD_DIR"
rm -f "$LOG_FILE"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f list.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^NO ERRORS$" "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG_FILE"
    exit 1
fi

/* src/eightRam.sv */
// scan starts on window fall and takes up to 67 cycles; slots above spriteCount keep stale words
`timescale 1ns/1ps

module eightRam #(
    parameter int gameStartY = 4
) (
    input  logic              clkEightRam,
    input  logic              rstn,
    input  ppuPkg::posXY      vgaPosY,
    input  logic              isGameWindow,
    output ppuPkg::oamAddr    readAddr,
    input  ppuPkg::spriteWord readData,
    output ppuPkg::spriteWord slot0,
    output ppuPkg::spriteWord slot1,
    output ppuPkg::spriteWord slot2,
    output ppuPkg::spriteWord slot3,
    output ppuPkg::spriteWord slot4,
    output ppuPkg::spriteWord slot5,
    output ppuPkg::spriteWord slot6,
    output ppuPkg::spriteWord slot7,
    output ppuPkg::slotCount  spriteCount,
    output logic              lineReady
);
    import ppuPkg::*;

    localparam oamAddr lastAddrValue = oamAddr'(SPRITE_NUM_MAX - 1);

    evalState   state;
    logic       windowD0;
    logic       windowD1;
    logic       windowFall;
    posXY       posYReg;
    lineByte    targetLine;
    oamAddr     addrCnt;
    logic       readValidD;
    slotCount   slotCnt;
    slotCount   slotCntNext;
    spriteWord  slotReg [SLOT_NUM];
    lineByte    spriteY;
    logic [8:0] targetWide;
    logic [8:0] spriteTop;
    logic [8:0] spriteEnd;
    logic       spriteHit;
    logic       slotWrite;
    logic       lastAddr;
    logic       slotsFull;

    // two-stage window sample, fall seen one cycle after it happens
    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            windowD0 <= 1'b0;
            windowD1 <= 1'b0;
            posYReg  <= '0;
        end else begin
            windowD0 <= isGameWindow;
            windowD1 <= windowD0;
            posYReg  <= vgaPosY;
        end
    end

    assign windowFall = windowD1 & ~windowD0;

    // Y byte of the word coming back from memory
    assign spriteY = readData[SPRITE_Y_LSB +: 8];

    // 9-bit compare so Y plus height never wraps past 255
    assign targetWide = {1'b0, targetLine};
    assign spriteTop  = {1'b0, spriteY};
    assign spriteEnd  = spriteTop + 9'(SPRITE_HEIGHT);
    assign spriteHit  = (targetWide >= spriteTop) && (targetWide < spriteEnd);

    // data is valid one cycle after its address was issued
    assign slotWrite   = readValidD && spriteHit && (slotCnt < slotCount'(SLOT_NUM));
    assign slotCntNext = slotCnt + slotCount'(slotWrite);
    assign lastAddr    = (addrCnt == lastAddrValue);
    assign slotsFull   = slotWrite && (slotCnt == slotCount'(SLOT_NUM - 1));

    // evaluation FSM
    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            state      <= idle;
            addrCnt    <= '0;
            targetLine <= '0;
        end else begin
            case (state)
                idle: begin
                    if (windowFall) begin
                        state      <= scan;
                        addrCnt    <= '0;
                        // game line after the one just drawn
                        targetLine <= lineByte'(posYReg - posXY'(gameStartY) + posXY'(1));
                    end
                end
                scan: begin
                    addrCnt <= addrCnt + oamAddr'(1);
                    if (lastAddr || slotsFull) begin
                        state <= done;
                    end
                end
                done: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // slot fill and line result
    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            readValidD  <= 1'b0;
            slotCnt     <= '0;
            spriteCount <= '0;
            lineReady   <= 1'b0;
        end else begin
            readValidD <= (state == scan);
            if (state == idle && windowFall) begin
                slotCnt <= '0;
            end else begin
                slotCnt <= slotCntNext;
            end
            // last read lands while in done, so take the updated count
            lineReady <= (state == done);
            if (state == done) begin
                spriteCount <= slotCntNext;
            end
        end
    end

    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            for (int i = 0; i < SLOT_NUM; i++) begin
                slotReg[i] <= '0;
            end
        end else if (slotWrite) begin
            slotReg[slotCnt[2:0]] <= readData;
        end
    end

    assign readAddr = addrCnt;

    assign slot0 = slotReg[0];
    assign slot1 = slotReg[1];
    assign slot2 = slotReg[2];
    assign slot3 = slotReg[3];
    assign slot4 = slotReg[4];
    assign slot5 = slotReg[5];
    assign slot6 = slotReg[6];
    assign slot7 = slotReg[7];

    slotCntBound: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        slotCnt <= slotCount'(SLOT_NUM)
    ) else $error("eightRam: slot counter above eight");

    readyNotInScan: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        lineReady |-> (state != scan)
    ) else $error("eightRam: lineReady while scanning");

    addrHoldInIdle: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        (state == idle) |=> (state != idle) || $stable(readAddr)
    ) else $error("eightRam: readAddr moved while idle");

    // next window fall must find the previous scan finished
    fallWhileIdle: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        windowFall |-> (state == idle)
    ) else $error("eightRam: window fell before scan finished");

endmodule

/* src/ppuPkg.sv */
// shared sprite evaluation types; sprite Y sits in bits 23:16 of each word, other bits pass through
package ppuPkg;

    // one sprite attribute entry
    // bits 23:16 hold the top game line of the sprite
    typedef logic [31:0] spriteWord;

    // sprite memory address, 64 entries
    typedef logic [5:0] oamAddr;

    // raster coordinate for both X and Y
    typedef logic [9:0] posXY;

    // game line or sprite Y value
    typedef logic [7:0] lineByte;

    // filled slot count, 0 to 8
    typedef logic [3:0] slotCount;

    // number of entries in sprite attribute memory
    localparam int SPRITE_NUM_MAX = 64;

    // most sprites kept for one line
    localparam int SLOT_NUM = 8;

    // every sprite is this many lines tall
    localparam int SPRITE_HEIGHT = 8;

    // where the sprite Y byte lives in a word
    localparam int SPRITE_Y_LSB = 16;

    // line evaluator FSM
    typedef enum logic [1:0] {
        idle,
        scan,
        done
    } evalState;

endpackage

/* src/scanTimer.sv */
// raster counters start at zero after reset; game rectangle must fit inside hTotal by vTotal
`timescale 1ns/1ps

module scanTimer #(
    parameter int hTotal     = 160,
    parameter int vTotal     = 40,
    parameter int gameStartX = 16,
    parameter int gameWidth  = 64,
    parameter int gameStartY = 4,
    parameter int gameHeight = 32
) (
    input  logic         clkEightRam,
    input  logic         rstn,
    output ppuPkg::posXY vgaPosX,
    output ppuPkg::posXY vgaPosY,
    output logic         isGameWindow
);
    import ppuPkg::*;

    // wrap points of the raster
    localparam posXY xLast = posXY'(hTotal - 1);
    localparam posXY yLast = posXY'(vTotal - 1);

    // game rectangle, end bounds exclusive
    localparam posXY xStart = posXY'(gameStartX);
    localparam posXY xEnd   = posXY'(gameStartX + gameWidth);
    localparam posXY yStart = posXY'(gameStartY);
    localparam posXY yEnd   = posXY'(gameStartY + gameHeight);

    posXY       nextX;
    posXY       nextY;
    logic       lineWrap;
    logic       nextInside;
    logic [7:0] lowRun;

    assign lineWrap = (vgaPosX == xLast);

    // position for the coming cycle
    always_comb begin
        nextX = lineWrap ? '0 : vgaPosX + posXY'(1);
        nextY = vgaPosY;
        if (lineWrap) begin
            nextY = (vgaPosY == yLast) ? '0 : vgaPosY + posXY'(1);
        end
    end

    // window level is computed from the next position
    // so it lines up with the registered position outputs
    assign nextInside = (nextX >= xStart) && (nextX < xEnd) &&
                        (nextY >= yStart) && (nextY < yEnd);

    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            vgaPosX      <= '0;
            vgaPosY      <= '0;
            isGameWindow <= 1'b0;
        end else begin
            vgaPosX      <= nextX;
            vgaPosY      <= nextY;
            isGameWindow <= nextInside;
        end
    end

    // length of the current low stretch of the window, saturating
    always_ff @(posedge clkEightRam) begin
        if (!rstn) begin
            lowRun <= '0;
        end else if (isGameWindow) begin
            lowRun <= '0;
        end else if (lowRun != 8'hff) begin
            lowRun <= lowRun + 8'd1;
        end
    end

    // window only inside the game rectangle
    windowInside: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        isGameWindow |-> (vgaPosX >= xStart) && (vgaPosX < xEnd) &&
                         (vgaPosY >= yStart) && (vgaPosY < yEnd)
    ) else $error("scanTimer: window high outside game rectangle");

    // blank between two window stretches leaves room for a full sprite scan
    blankLongEnough: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        $rose(isGameWindow) |-> (lowRun >= 8'd72)
    ) else $error("scanTimer: blank after window shorter than 72 cycles");

endmodule

/* src/spriteLineUnit.sv */
// one host write strobe per cycle, no back-pressure; blank after each game line must cover a scan
`timescale 1ns/1ps

module spriteLineUnit #(
    parameter int hTotal     = 160,
    parameter int vTotal     = 40,
    parameter int gameStartX = 16,
    parameter int gameWidth  = 64,
    parameter int gameStartY = 4,
    parameter int gameHeight = 32
) (
    input  logic              clkEightRam,
    input  logic              rstn,
    // host write port
    input  logic              oamWe,
    input  ppuPkg::oamAddr    oamWrAddr,
    input  ppuPkg::spriteWord oamWrData,
    // raster
    output ppuPkg::posXY      vgaPosX,
    output ppuPkg::posXY      vgaPosY,
    output logic              isGameWindow,
    // sprites found for the next line
    output ppuPkg::spriteWord slot0,
    output ppuPkg::spriteWord slot1,
    output ppuPkg::spriteWord slot2,
    output ppuPkg::spriteWord slot3,
    output ppuPkg::spriteWord slot4,
    output ppuPkg::spriteWord slot5,
    output ppuPkg::spriteWord slot6,
    output ppuPkg::spriteWord slot7,
    output ppuPkg::slotCount  spriteCount,
    output logic              lineReady
);
    import ppuPkg::*;

    oamAddr    readAddr;
    spriteWord readData;

    spriteRam uSpriteRam (
        .clkEightRam (clkEightRam),
        .we          (oamWe),
        .wrAddr      (oamWrAddr),
        .wrData      (oamWrData),
        .rdAddr      (readAddr),
        .rdData      (readData)
    );

    scanTimer #(
        .hTotal     (hTotal),
        .vTotal     (vTotal),
        .gameStartX (gameStartX),
        .gameWidth  (gameWidth),
        .gameStartY (gameStartY),
        .gameHeight (gameHeight)
    ) uScanTimer (
        .clkEightRam  (clkEightRam),
        .rstn         (rstn),
        .vgaPosX      (vgaPosX),
        .vgaPosY      (vgaPosY),
        .isGameWindow (isGameWindow)
    );

    // evaluator sees the same position and window the outside world sees
    eightRam #(
        .gameStartY (gameStartY)
    ) uEightRam (
        .clkEightRam  (clkEightRam),
        .rstn         (rstn),
        .vgaPosY      (vgaPosY),
        .isGameWindow (isGameWindow),
        .readAddr     (readAddr),
        .readData     (readData),
        .slot0        (slot0),
        .slot1        (slot1),
        .slot2        (slot2),
        .slot3        (slot3),
        .slot4        (slot4),
        .slot5        (slot5),
        .slot6        (slot6),
        .slot7        (slot7),
        .spriteCount  (spriteCount),
        .lineReady    (lineReady)
    );

endmodule

/* src/spriteRam.sv */
// no reset on the array, contents are undefined until written; host must keep we known from time zero
`timescale 1ns/1ps

module spriteRam (
    input  logic              clkEightRam,
    input  logic              we,
    input  ppuPkg::oamAddr    wrAddr,
    input  ppuPkg::spriteWord wrData,
    input  ppuPkg::oamAddr    rdAddr,
    output ppuPkg::spriteWord rdData
);
    import ppuPkg::*;

    // attribute table, one word per sprite
    spriteWord mem [SPRITE_NUM_MAX];

    // single write port, registered read port
    // a write shows up on a read of the same address one cycle later
    always_ff @(posedge clkEightRam) begin
        if (we) begin
            mem[wrAddr] <= wrData;
        end
        rdData <= mem[rdAddr];
    end

    // host strobe must always be a clean level
    weKnown: assert property (
        @(posedge clkEightRam)
        !$isunknown(we)
    ) else $error("spriteRam: write strobe is unknown");

    // a write must also carry a defined address and payload
    writeKnown: assert property (
        @(posedge clkEightRam)
        we |-> !$isunknown(wrAddr) && !$isunknown(wrData)
    ) else $error("spriteRam: write with unknown address or data");

endmodule

/* testbench/tbSpriteLine.sv */
// runs with the default raster timing; sprite table is rewritten only at frame start outside any scan
`timescale 1ns/1ps

module tbSpriteLine;
    import ppuPkg::*;

    localparam int hTotal       = 160;
    localparam int vTotal       = 40;
    localparam int gameStartX   = 16;
    localparam int gameWidth    = 64;
    localparam int gameStartY   = 4;
    localparam int gameHeight   = 32;
    localparam int frameCycles  = hTotal * vTotal;
    localparam int pulseWaitMax = 10 * hTotal;
    // Y byte 10 covers lines 10 to 17
    localparam spriteWord markerWord = 32'hC30A0505;

    logic        clkEightRam;
    logic        rstn;
    logic        oamWe;
    oamAddr      oamWrAddr;
    spriteWord   oamWrData;
    posXY        vgaPosX;
    posXY        vgaPosY;
    logic        isGameWindow;
    spriteWord   slotOut [SLOT_NUM];
    slotCount    spriteCount;
    logic        lineReady;

    spriteWord   shadow [SPRITE_NUM_MAX];
    logic [15:0] lfsrState;
    posXY        fallY;
    logic        windowPrev;
    logic        pulsePending;
    logic        markerActive;
    int          refX;
    int          refY;
    logic        expWindow;
    int          pulseTotal;
    int          markerHits;
    int          lineChecks;
    int          lineMismatches;
    int          rasterMismatches;
    int          pulseFailures;
    int          flowFailures;
    int          assertFailures;

    spriteLineUnit #(
        .hTotal     (hTotal),
        .vTotal     (vTotal),
        .gameStartX (gameStartX),
        .gameWidth  (gameWidth),
        .gameStartY (gameStartY),
        .gameHeight (gameHeight)
    ) UUT (
        .clkEightRam  (clkEightRam),
        .rstn         (rstn),
        .oamWe        (oamWe),
        .oamWrAddr    (oamWrAddr),
        .oamWrData    (oamWrData),
        .vgaPosX      (vgaPosX),
        .vgaPosY      (vgaPosY),
        .isGameWindow (isGameWindow),
        .slot0        (slotOut[0]),
        .slot1        (slotOut[1]),
        .slot2        (slotOut[2]),
        .slot3        (slotOut[3]),
        .slot4        (slotOut[4]),
        .slot5        (slotOut[5]),
        .slot6        (slotOut[6]),
        .slot7        (slotOut[7]),
        .spriteCount  (spriteCount),
        .lineReady    (lineReady)
    );

    initial clkEightRam = 1'b0;
    always #4 clkEightRam = ~clkEightRam;

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // expected slot list for the line after the one that just closed
    task automatic compareLine();
        spriteWord expList [SLOT_NUM];
        int        target;
        int        expCount;
        int        a;
        int        s;
        int        y;
        target   = int'(fallY) - gameStartY + 1;
        expCount = 0;
        for (a = 0; a < SPRITE_NUM_MAX; a++) begin
            // sprite Y sits in bits 23:16 and covers Y up to Y plus height minus one
            y = int'(shadow[a][23:16]);
            if (expCount < SLOT_NUM && target >= y && target < y + SPRITE_HEIGHT) begin
                expList[expCount] = shadow[a];
                expCount++;
            end
        end
        lineChecks++;
        assert (int'(spriteCount) == expCount) else begin
            lineMismatches++;
            $display("Mismatch at %0t: spriteCount for line %0d expected %0d got %0d",
                     $time, target, expCount, spriteCount);
        end
        for (s = 0; s < expCount; s++) begin
            assert (slotOut[s] == expList[s]) else begin
                lineMismatches++;
                $display("Mismatch at %0t: slot%0d for line %0d expected %h got %h",
                         $time, s, target, expList[s], slotOut[s]);
            end
        end
        for (s = 0; s < int'(spriteCount) && s < SLOT_NUM; s++) begin
            if (markerActive && slotOut[s] == markerWord) begin
                markerHits++;
            end
        end
    endtask

    // one pulse owed per window fall and a compare on each pulse
    always @(negedge clkEightRam) begin
        if (rstn) begin
            if (windowPrev && !isGameWindow) begin
                assert (!pulsePending) else begin
                    pulseFailures++;
                    $display("a game line ended at %0t before the previous line got lineReady",
                             $time);
                end
                pulsePending = 1'b1;
                fallY        = vgaPosY;
            end
            if (lineReady) begin
                assert (pulsePending) else begin
                    pulseFailures++;
                    $display("lineReady pulsed at %0t with no game line ended before it", $time);
                end
                pulsePending = 1'b0;
                pulseTotal++;
                compareLine();
            end
            windowPrev = isGameWindow;
        end
    end

    // reference raster from the reset values and wrap rules
    always @(posedge clkEightRam) begin
        if (!rstn) begin
            refX <= 0;
            refY <= 0;
        end else if (refX == hTotal - 1) begin
            refX <= 0;
            refY <= (refY == vTotal - 1) ? 0 : refY + 1;
        end else begin
            refX <= refX + 1;
        end
    end

    assign expWindow = (refX >= gameStartX) && (refX < gameStartX + gameWidth) &&
                       (refY >= gameStartY) && (refY < gameStartY + gameHeight);

    // raster outputs against the reference position and game rectangle
    always @(negedge clkEightRam) begin
        if (rstn) begin
            assert (int'(vgaPosX) == refX) else begin
                rasterMismatches++;
                $display("Mismatch at %0t: vgaPosX expected %0d got %0d", $time, refX, vgaPosX);
            end
            assert (int'(vgaPosY) == refY) else begin
                rasterMismatches++;
                $display("Mismatch at %0t: vgaPosY expected %0d got %0d", $time, refY, vgaPosY);
            end
            assert (isGameWindow == expWindow) else begin
                rasterMismatches++;
                $display("Mismatch at %0t: isGameWindow expected %0b got %0b",
                         $time, expWindow, isGameWindow);
            end
        end
    end

    noPulseInWindow: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        lineReady |-> !isGameWindow
    ) else begin
        assertFailures++;
        $display("lineReady pulsed at %0t while the game window was open", $time);
    end

    singleCyclePulse: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        lineReady |=> !lineReady
    ) else begin
        assertFailures++;
        $display("lineReady stayed high for more than one cycle at %0t", $time);
    end

    countOnlyWithPulse: assert property (
        @(posedge clkEightRam) disable iff (!rstn)
        !$stable(spriteCount) |-> lineReady
    ) else begin
        assertFailures++;
        $display("spriteCount changed at %0t without a lineReady pulse", $time);
    end

    task automatic writeSprite(input int addr, input spriteWord data);
        oamWe        = 1'b1;
        oamWrAddr    = oamAddr'(addr);
        oamWrData    = data;
        shadow[addr] = data;
        @(negedge clkEightRam);
        oamWe = 1'b0;
    endtask

    // Y from 0 to 63 gives lines from empty up to overflow
    task automatic loadRandomTable();
        logic [31:0] payload;
        logic [31:0] yBits;
        int          i;
        for (i = 0; i < SPRITE_NUM_MAX; i++) begin
            payload = randomBits(24);
            yBits   = randomBits(6);
            writeSprite(i, {payload[23:16], 2'b00, yBits[5:0], payload[15:0]});
        end
    endtask

    // twelve sprites on Y 12 at addresses 3, 7 and so on up to 47
    task automatic loadOverflowTable();
        int i;
        for (i = 0; i < SPRITE_NUM_MAX; i++) begin
            if (i % 4 == 3 && i < 48) begin
                writeSprite(i, {8'(i), 8'd12, 8'hE1, 8'(i)});
            end else begin
                writeSprite(i, {8'(i), 8'd100, 8'h1E, 8'(i)});
            end
        end
    endtask

    // Y 250 and 255 would wrap onto low lines with an 8-bit compare
    task automatic loadEdgeTable();
        int i;
        for (i = 0; i < SPRITE_NUM_MAX; i++) begin
            if (i == 5) begin
                writeSprite(i, markerWord);
            end else if (i == 40) begin
                writeSprite(i, {8'h40, 8'd30, 16'h7E40});
            end else if (i == 63) begin
                writeSprite(i, {8'h3F, 8'd255, 16'h0F0F});
            end else begin
                writeSprite(i, {8'(i), 8'd250, 8'h3C, 8'(i)});
            end
        end
    endtask

    task automatic waitFrameStart(output logic ok);
        int waited;
        waited = 0;
        while (!(vgaPosX == '0 && vgaPosY == '0) && waited < frameCycles + hTotal) begin
            @(negedge clkEightRam);
            waited++;
        end
        ok = (vgaPosX == '0 && vgaPosY == '0);
        if (!ok) begin
            flowFailures++;
            $display("Timeout at %0t: the next frame never started", $time);
        end
    endtask

    task automatic waitLines(input int count, output logic ok);
        int seen;
        int waited;
        ok = 1'b1;
        for (seen = 0; seen < count && ok; seen++) begin
            waited = 0;
            @(negedge clkEightRam);
            while (!lineReady && waited < pulseWaitMax) begin
                @(negedge clkEightRam);
                waited++;
            end
            if (!lineReady) begin
                ok = 1'b0;
                flowFailures++;
                $display("Timeout at %0t: lineReady never came for game line %0d", $time, seen);
            end
        end
    endtask

    // outputs stay at their reset values until the first game line closes
    task automatic checkIdleOutputs(output logic ok);
        logic seenHigh;
        int   waited;
        int   s;
        seenHigh = 1'b0;
        waited   = 0;
        while (!(seenHigh && !isGameWindow) && waited < frameCycles) begin
            assert (!lineReady) else begin
                flowFailures++;
                $display("lineReady pulsed at %0t before any game line ended", $time);
            end
            assert (spriteCount == '0) else begin
                flowFailures++;
                $display("Mismatch at %0t: spriteCount expected 0 got %0d", $time, spriteCount);
            end
            for (s = 0; s < SLOT_NUM; s++) begin
                assert (slotOut[s] == '0) else begin
                    flowFailures++;
                    $display("Mismatch at %0t: slot%0d expected 0 got %h", $time, s, slotOut[s]);
                end
            end
            if (isGameWindow) begin
                seenHigh = 1'b1;
            end
            @(negedge clkEightRam);
            waited++;
        end
        ok = seenHigh && !isGameWindow;
        if (!ok) begin
            flowFailures++;
            $display("Timeout at %0t: the first game line never closed after reset", $time);
        end
    endtask

    task automatic runTests();
        logic ok;
        waitFrameStart(ok);
        if (!ok) return;
        loadRandomTable();
        checkIdleOutputs(ok);
        if (!ok) return;
        waitLines(gameHeight, ok);
        if (!ok) return;
        waitFrameStart(ok);
        if (!ok) return;
        loadOverflowTable();
        waitLines(gameHeight, ok);
        if (!ok) return;
        waitFrameStart(ok);
        if (!ok) return;
        loadEdgeTable();
        markerActive = 1'b1;
        waitLines(gameHeight, ok);
        if (!ok) return;
        // let the checker finish the last pulse
        @(negedge clkEightRam);
        assert (markerHits == SPRITE_HEIGHT) else begin
            flowFailures++;
            $display("Mismatch at %0t: marker sprite lines expected %0d got %0d",
                     $time, SPRITE_HEIGHT, markerHits);
        end
        assert (pulseTotal == 3 * gameHeight) else begin
            flowFailures++;
            $display("Mismatch at %0t: lineReady pulses expected %0d got %0d",
                     $time, 3 * gameHeight, pulseTotal);
        end
    endtask

    task automatic finishRun();
        int total;
        total = lineMismatches + rasterMismatches + pulseFailures + flowFailures +
                assertFailures;
        $display(
            "summary: %0d line checks, %0d mismatches, %0d raster, %0d pulse, %0d flow, %0d %s",
            lineChecks, lineMismatches, rasterMismatches, pulseFailures, flowFailures,
            assertFailures, "assertion errors");
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin
        rstn             = 1'b0;
        oamWe            = 1'b0;
        oamWrAddr        = '0;
        oamWrData        = '0;
        lfsrState        = 16'd60;
        fallY            = '0;
        windowPrev       = 1'b0;
        pulsePending     = 1'b0;
        markerActive     = 1'b0;
        pulseTotal       = 0;
        markerHits       = 0;
        lineChecks       = 0;
        lineMismatches   = 0;
        rasterMismatches = 0;
        pulseFailures    = 0;
        flowFailures     = 0;
        assertFailures   = 0;
        repeat (2) @(negedge clkEightRam);
        rstn = 1'b1;
        runTests();
        finishRun();
    end

endmodule
